// ==== all.f ====
axil_pkg.sv
mem_pkg.sv
mm_if.sv
axil2mm_fsm.sv
mm_wait_timer.sv
mm_ram.sv
axil_mem_top.sv
tb_axil_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI-Lite memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_axil_mem -f all.f

status=0
output=$(./obj_dir/Vtb_axil_mem 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "Simulation run did not pass"
exit 1

// ==== tb_axil_mem.sv ====
//**********************************************************************
// Table-driven testbench; RAM content is not reset, so every word
// is written before it is read
//**********************************************************************
module tb_axil_mem import axil_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 4;
    localparam int N_ENTRIES       = 17;
    localparam int RESP_LIMIT      = 16;
    localparam int WATCHDOG_CYCLES = N_ENTRIES * 20 + RESET_CYCLES + 4;

    // Memory port latency per region, plus strobe and response cycles
    localparam int WAIT_LOW      = 2;
    localparam int WAIT_HIGH     = 5;
    localparam int RESP_OVERHEAD = 2;

    localparam logic [1:0] AXI_OKAY = 2'b00;
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_BOTH  = 2'd2;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } entry_t;

    logic       s_axi_clk;
    logic       s_axi_aresetn;
    axil_addr_t s_axi_awaddr;
    logic       s_axi_awvalid;
    logic       s_axi_awready;
    axil_data_t s_axi_wdata;
    axil_strb_t s_axi_wstrb;
    logic       s_axi_wvalid;
    logic       s_axi_wready;
    axil_resp_t s_axi_bresp;
    logic       s_axi_bvalid;
    logic       s_axi_bready;
    axil_addr_t s_axi_araddr;
    logic       s_axi_arvalid;
    logic       s_axi_arready;
    axil_data_t s_axi_rdata;
    axil_resp_t s_axi_rresp;
    logic       s_axi_rvalid;
    logic       s_axi_rready;

    entry_t      stim [N_ENTRIES];
    logic [31:0] model [64];
    logic [31:0] rng_state;
    int          error_count;
    int          check_count;

    axil_mem_top DUT (.*);

    initial begin
        s_axi_clk = 1'b0;
        forever #CLK_HALF s_axi_clk = ~s_axi_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge s_axi_clk);
        $display("Timeout after %0d clock cycles, transactions did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int expected_latency(input logic [31:0] addr);
        return RESP_OVERHEAD + (addr[7] ? WAIT_HIGH : WAIT_LOW);
    endfunction

    // Lanes with strb set take the new byte
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("FAIL %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("FAIL %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic load_table();
        stim[0]  = '{OP_WRITE, 32'h0000_0010, 32'hdead_beef, 4'hf};
        stim[1]  = '{OP_READ,  32'h0000_0010, 32'h0,         4'h0};
        stim[2]  = '{OP_WRITE, 32'h0000_0090, 32'h1234_5678, 4'hf};
        stim[3]  = '{OP_READ,  32'h0000_0090, 32'h0,         4'h0};
        // Aliases above byte address 255
        stim[4]  = '{OP_READ,  32'h0000_0110, 32'h0,         4'h0};
        stim[5]  = '{OP_WRITE, 32'h0000_0390, 32'ha5a5_5a5a, 4'hf};
        stim[6]  = '{OP_READ,  32'h0000_0090, 32'h0,         4'h0};
        // Partial strobes
        stim[7]  = '{OP_WRITE, 32'h0000_0010, 32'h1122_3344, 4'h5};
        stim[8]  = '{OP_READ,  32'h0000_0010, 32'h0,         4'h0};
        stim[9]  = '{OP_WRITE, 32'h0000_0090, 32'hffff_0000, 4'h8};
        stim[10] = '{OP_READ,  32'h8000_0090, 32'h0,         4'h0};
        // AW, W and AR together
        stim[11] = '{OP_BOTH,  32'h0000_0044, 32'hcafe_f00d, 4'hf};
        stim[12] = '{OP_BOTH,  32'h0000_00fc, 32'h0bad_c0de, 4'hf};
        stim[13] = '{OP_WRITE, 32'h0000_00fc, 32'h7700_0000, 4'h8};
        stim[14] = '{OP_READ,  32'h0000_00fc, 32'h0,         4'h0};
        stim[15] = '{OP_WRITE, 32'h0000_0044, 32'hffff_ffff, 4'h0};
        stim[16] = '{OP_READ,  32'h0000_0144, 32'h0,         4'h0};
    endtask

    task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        s_axi_wvalid  <= 1'b1;
    endtask

    // Counts from the edge where the idle bridge first sees the request
    task automatic complete_write(input logic [31:0] addr, input bit probe);
        int          cyc;
        int          delay;
        logic [31:0] rnd;
        cyc = 0;
        @(posedge s_axi_clk);
        while (s_axi_bvalid !== 1'b1 && cyc < RESP_LIMIT) begin
            check_bit("s_axi_awready", s_axi_awready, cyc == 1);
            check_bit("s_axi_wready", s_axi_wready, cyc == 1);
            check_bit("s_axi_arready", s_axi_arready, 1'b0);
            if (cyc == 1) begin
                s_axi_awvalid <= 1'b0;
                s_axi_wvalid  <= 1'b0;
            end
            @(posedge s_axi_clk);
            cyc++;
        end
        assert (s_axi_bvalid === 1'b1) else begin
            error_count++;
            $display("Write to %h got no write response", addr);
        end
        check_word("bvalid latency", cyc, expected_latency(addr));
        check_word("s_axi_bresp", {30'd0, s_axi_bresp}, {30'd0, AXI_OKAY});
        rnd = next_random();
        delay = int'(rnd[17:16]);
        for (int i = 0; i < delay; i++) begin
            // A read offered during the stall must wait
            if (probe) begin
                s_axi_araddr  <= addr;
                s_axi_arvalid <= 1'b1;
            end
            @(posedge s_axi_clk);
            check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);
            check_word("s_axi_bresp", {30'd0, s_axi_bresp}, {30'd0, AXI_OKAY});
            check_bit("s_axi_awready", s_axi_awready, 1'b0);
            check_bit("s_axi_arready", s_axi_arready, 1'b0);
        end
        s_axi_bready <= 1'b1;
        @(posedge s_axi_clk);
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);
        check_bit("s_axi_arready", s_axi_arready, 1'b0);
        s_axi_bready <= 1'b0;
        if (probe) begin
            s_axi_arvalid <= 1'b0;
        end
    endtask

    task automatic complete_read(input logic [31:0] addr, input logic [31:0] expected,
                                 input bit probe);
        int          cyc;
        int          delay;
        logic [31:0] rnd;
        cyc = 0;
        @(posedge s_axi_clk);
        while (s_axi_rvalid !== 1'b1 && cyc < RESP_LIMIT) begin
            check_bit("s_axi_arready", s_axi_arready, cyc == 1);
            check_bit("s_axi_awready", s_axi_awready, 1'b0);
            check_bit("s_axi_wready", s_axi_wready, 1'b0);
            if (cyc == 1) begin
                s_axi_arvalid <= 1'b0;
            end
            @(posedge s_axi_clk);
            cyc++;
        end
        assert (s_axi_rvalid === 1'b1) else begin
            error_count++;
            $display("Read from %h got no read data", addr);
        end
        check_word("rvalid latency", cyc, expected_latency(addr));
        check_word("s_axi_rdata", s_axi_rdata, expected);
        check_word("s_axi_rresp", {30'd0, s_axi_rresp}, {30'd0, AXI_OKAY});
        rnd = next_random();
        delay = int'(rnd[17:16]);
        for (int i = 0; i < delay; i++) begin
            // Inverted full write offered during the stall, must not be taken
            if (probe) begin
                send_write(addr, ~expected, 4'hf);
            end
            @(posedge s_axi_clk);
            check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
            check_word("s_axi_rdata", s_axi_rdata, expected);
            check_bit("s_axi_awready", s_axi_awready, 1'b0);
            check_bit("s_axi_arready", s_axi_arready, 1'b0);
        end
        s_axi_rready <= 1'b1;
        @(posedge s_axi_clk);
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
        check_bit("s_axi_awready", s_axi_awready, 1'b0);
        s_axi_rready  <= 1'b0;
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
    endtask

    initial begin
        entry_t e;
        error_count   = 0;
        check_count   = 0;
        rng_state     = 32'h273b;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            model[i] = 32'h0;
        end
        load_table();

        repeat (RESET_CYCLES) @(posedge s_axi_clk);
        check_bit("s_axi_awready", s_axi_awready, 1'b0);
        check_bit("s_axi_wready", s_axi_wready, 1'b0);
        check_bit("s_axi_arready", s_axi_arready, 1'b0);
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
        check_word("s_axi_bresp", {30'd0, s_axi_bresp}, {30'd0, AXI_OKAY});
        check_word("s_axi_rresp", {30'd0, s_axi_rresp}, {30'd0, AXI_OKAY});
        s_axi_aresetn <= 1'b1;

        for (int k = 0; k < N_ENTRIES; k++) begin
            e = stim[k];
            @(posedge s_axi_clk);
            case (e.op)
                OP_WRITE: begin
                    send_write(e.addr, e.data, e.strb);
                    model[e.addr[7:2]] = merge_bytes(model[e.addr[7:2]], e.data, e.strb);
                    complete_write(e.addr, 1'b1);
                end
                OP_READ: begin
                    s_axi_araddr  <= e.addr;
                    s_axi_arvalid <= 1'b1;
                    complete_read(e.addr, model[e.addr[7:2]], 1'b1);
                end
                default: begin
                    // Write first, the read stays pending on AR
                    send_write(e.addr, e.data, e.strb);
                    s_axi_araddr  <= e.addr;
                    s_axi_arvalid <= 1'b1;
                    model[e.addr[7:2]] = merge_bytes(model[e.addr[7:2]], e.data, e.strb);
                    complete_write(e.addr, 1'b0);
                    complete_read(e.addr, model[e.addr[7:2]], 1'b0);
                end
            endcase
        end

        @(posedge s_axi_clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== axil_mem_top.sv ====
//**********************************************************************
// AXI4-Lite word memory, 256-byte window aliased over the address space
// Latency 2 waits below 0x80 and 5 waits above, responses always OKAY
//**********************************************************************
module axil_mem_top import axil_pkg::*; (
    input  logic       s_axi_clk,
    input  logic       s_axi_aresetn,
    // Write address
    input  axil_addr_t s_axi_awaddr,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    // Write data
    input  axil_data_t s_axi_wdata,
    input  axil_strb_t s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    // Write response
    output axil_resp_t s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    // Read address
    input  axil_addr_t s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    // Read data
    output axil_data_t s_axi_rdata,
    output axil_resp_t s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready
);

    mm_if mem_bus ();

    axil2mm_fsm u_bridge (
        .s_axi_clk     (s_axi_clk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .mem           (mem_bus)
    );

    // Sets the access latency per region
    mm_wait_timer u_timer (
        .s_axi_clk     (s_axi_clk),
        .s_axi_aresetn (s_axi_aresetn),
        .mem           (mem_bus)
    );

    mm_ram u_ram (
        .s_axi_clk (s_axi_clk),
        .mem       (mem_bus)
    );

endmodule

// ==== mm_ram.sv ====
//**********************************************************************
// 64 x 32 word RAM with byte-lane writes and registered read data
// Contents are not cleared by reset
//**********************************************************************
module mm_ram import axil_pkg::*, mem_pkg::*; (
    input logic s_axi_clk,
    mm_if.ram   mem
);

    axil_data_t ram_q [MEM_DEPTH];

    // Write lanes under strb
    always_ff @(posedge s_axi_clk) begin
        if (mem.we) begin
            for (int i = 0; i < $bits(axil_strb_t); i++) begin
                if (mem.strb[i]) begin
                    ram_q[mem.index][8*i +: 8] <= mem.d[8*i +: 8];
                end
            end
        end
    end

    // spo holds the word until the next rd
    always_ff @(posedge s_axi_clk) begin
        if (mem.rd) begin
            mem.spo <= ram_q[mem.index];
        end
    end

    a_rd_we_exclusive: assert property (@(posedge s_axi_clk)
        mem.we |-> !mem.rd);

endmodule

// ==== mm_wait_timer.sv ====
//**********************************************************************
// Returns ready exactly N cycles after a rd or we strobe
// N is taken from the region bit of a in the strobe cycle
//**********************************************************************
module mm_wait_timer import axil_pkg::*, mem_pkg::*; (
    input logic  s_axi_clk,
    input logic  s_axi_aresetn,
    mm_if.timer  mem
);

    localparam axil_addr_t REGION_MASK = axil_addr_t'(1) << REGION_BIT;

    wait_count_t count_q;
    wait_count_t load_val;
    logic        strobe;

    assign strobe = mem.rd || mem.we;

    // Loaded one short since the strobe cycle itself counts
    assign load_val = ((mem.a & REGION_MASK) != '0) ? WAIT_SLOW - wait_count_t'(1)
                                                    : WAIT_FAST - wait_count_t'(1);

    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_aresetn) begin
            count_q   <= '0;
            mem.ready <= 1'b0;
        end else begin
            mem.ready <= 1'b0;
            if (strobe) begin
                count_q <= load_val;
            end else if (count_q != '0) begin
                count_q <= count_q - 1'b1;
                // Last count, ready goes out next cycle
                if (count_q == wait_count_t'(1)) begin
                    mem.ready <= 1'b1;
                end
            end
        end
    end

    a_ready_after_strobe: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
        mem.ready |-> $past(mem.rd || mem.we, WAIT_FAST) || $past(mem.rd || mem.we, WAIT_SLOW));

    // Bridge must wait for ready before the next strobe
    a_no_strobe_busy: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
        strobe |-> count_q == '0);

endmodule

// ==== axil2mm_fsm.sv ====
//**********************************************************************
// AXI4-Lite slave handling one transaction at a time, writes before reads
// AW and W must be valid in the same cycle to start a write
//**********************************************************************
module axil2mm_fsm import axil_pkg::*; (
    input  logic       s_axi_clk,
    input  logic       s_axi_aresetn,
    // Write address
    input  axil_addr_t s_axi_awaddr,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    // Write data
    input  axil_data_t s_axi_wdata,
    input  axil_strb_t s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    // Write response
    output axil_resp_t s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    // Read address
    input  axil_addr_t s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    // Read data
    output axil_data_t s_axi_rdata,
    output axil_resp_t s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    // Memory port
    mm_if.bridge       mem
);

    bridge_state_e wr_state;
    bridge_state_e rd_state;

    logic wr_start;
    logic rd_start;

    // Both machines must be idle and a full write request defers a read
    assign wr_start = (wr_state == IDLE) && (rd_state == IDLE)
                      && s_axi_awvalid && s_axi_wvalid;
    assign rd_start = (wr_state == IDLE) && (rd_state == IDLE)
                      && s_axi_arvalid && !(s_axi_awvalid && s_axi_wvalid);

    // No error decoding
    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;

    always_ff @(posedge s_axi_clk) begin
        if (!s_axi_aresetn) begin
            wr_state      <= IDLE;
            rd_state      <= IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            mem.we        <= 1'b0;
            mem.rd        <= 1'b0;
        end else begin
            // Handshake and strobe are single-cycle pulses
            s_axi_awready <= wr_start;
            s_axi_wready  <= wr_start;
            mem.we        <= wr_start;
            s_axi_arready <= rd_start;
            mem.rd        <= rd_start;

            case (wr_state)
                IDLE: begin
                    if (wr_start) begin
                        wr_state <= WAIT_READY;
                    end
                end
                WAIT_READY: begin
                    if (mem.ready) begin
                        s_axi_bvalid <= 1'b1;
                        wr_state     <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (s_axi_bready) begin
                        s_axi_bvalid <= 1'b0;
                        wr_state     <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase

            case (rd_state)
                IDLE: begin
                    if (rd_start) begin
                        rd_state <= WAIT_READY;
                    end
                end
                WAIT_READY: begin
                    if (mem.ready) begin
                        s_axi_rvalid <= 1'b1;
                        rd_state     <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (s_axi_rready) begin
                        s_axi_rvalid <= 1'b0;
                        rd_state     <= IDLE;
                    end
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    // Address, data and read word held for the memory port and the R channel
    always_ff @(posedge s_axi_clk) begin
        if (wr_start) begin
            mem.a    <= s_axi_awaddr;
            mem.d    <= s_axi_wdata;
            mem.strb <= s_axi_wstrb;
        end else if (rd_start) begin
            mem.a <= s_axi_araddr;
        end
        // spo was captured on the rd cycle and is still held here
        if ((rd_state == WAIT_READY) && mem.ready) begin
            s_axi_rdata <= mem.spo;
        end
    end

    // Ready only ends an access that one of the machines waits for
    a_ready_expected: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
        mem.ready |-> (wr_state == WAIT_READY) || (rd_state == WAIT_READY));

    a_bvalid_hold: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

    // Read data must not move while the master stalls
    a_rvalid_hold: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// ==== mm_if.sv ====
//**********************************************************************
// Memory port: one strobe at a time, a and d held until ready
//**********************************************************************
interface mm_if import axil_pkg::*, mem_pkg::*; ();

    // Request side, driven by the bridge
    axil_addr_t a;
    axil_data_t d;
    axil_strb_t strb;
    logic       rd;
    logic       we;

    // Completion side
    axil_data_t spo;
    logic       ready;

    // Word index into the RAM, aliasing above bit 7
    mem_index_t index;

    assign index = a[INDEX_LSB +: $bits(mem_index_t)];

    modport bridge (output a, d, strb, rd, we, input spo, ready);

    modport timer (input a, rd, we, output ready);

    modport ram (input a, index, d, strb, rd, we, output spo);

endinterface

// ==== mem_pkg.sv ====
//**********************************************************************
// Memory-side map: 64 words, higher byte-address bits alias
// Address bit 7 picks the slow region; wait counts must be 2 or more
//**********************************************************************
package mem_pkg;

    // Word index taken from byte-address bits 7:2
    typedef logic [5:0] mem_index_t;

    localparam int MEM_DEPTH = 64;
    localparam int INDEX_LSB = 2;

    // Address bit that selects the latency region
    localparam int REGION_BIT = 7;

    // Wide enough for the slow region count
    typedef logic [2:0] wait_count_t;

    // Cycles from strobe to ready per region
    localparam wait_count_t WAIT_FAST = 3'd2;
    localparam wait_count_t WAIT_SLOW = 3'd5;

endpackage

// ==== axil_pkg.sv ====
//**********************************************************************
// AXI4-Lite types for a 32-bit data bus with 4 byte lanes
// Only the OKAY response is produced; no protection or error codes
//**********************************************************************
package axil_pkg;

    // Byte address as seen on the AW and AR channels
    typedef logic [31:0] axil_addr_t;

    // One bus word and its byte-lane enables
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    // BRESP / RRESP encoding
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    // Shared by the write and the read machine of the bridge
    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        RESPOND
    } bridge_state_e;

endpackage
